/* blob_tracker_top.f */
hdl/video_pkg.sv
hdl/track_pkg.sv
hdl/pixel_capture.sv
hdl/chroma_mask.sv
hdl/serial_divider.sv
hdl/centroid_accum.sv
hdl/crosshair_overlay.sv
hdl/blob_tracker_top.sv
tests/tb_blob_tracker_top.sv

/* hdl/blob_tracker_top.sv */
`default_nettype none

module blob_tracker_top #(
   parameter int                 FRAME_W = video_pkg::FRAME_W_DEFAULT,
   parameter int                 FRAME_H = video_pkg::FRAME_H_DEFAULT,
   parameter track_pkg::chroma_t CR_LOW  = track_pkg::CR_LOW_DEFAULT,
   parameter track_pkg::chroma_t CR_HIGH = track_pkg::CR_HIGH_DEFAULT
) (
   input  wire                        clk_camera,
   input  wire                        sys_rst_camera,
   input  wire video_pkg::cam_bus_t   cam_bus_i,
   input  wire video_pkg::disp_mode_e mode_i,
   output video_pkg::pixel_t          disp_o,
   output track_pkg::com_t            com_o,
   output logic                       com_valid_o
);

   import video_pkg::*;
   import track_pkg::*;

   // rebuilt camera pixels
   pixel_t cam_pixel;
   // mask result, 3 cycles behind cam_pixel
   logic   mask_valid;
   logic   mask;
   com_t   mask_pos;

   pixel_capture #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H)
   ) capture_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .bus_i          (cam_bus_i),
      .pixel_o        (cam_pixel)
   );

   chroma_mask #(
      .CR_LOW (CR_LOW),
      .CR_HIGH(CR_HIGH)
   ) mask_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_i        (cam_pixel),
      .mask_valid_o   (mask_valid),
      .mask_o         (mask),
      .mask_pos_o     (mask_pos)
   );

   centroid_accum #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H)
   ) accum_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_valid_i   (mask_valid),
      .mask_i         (mask),
      .mask_pos_i     (mask_pos),
      .com_o          (com_o),
      .com_valid_o    (com_valid_o)
   );

   // draws with the centre of mass of the previous frame
   crosshair_overlay overlay_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_i        (cam_pixel),
      .mask_valid_i   (mask_valid),
      .mask_i         (mask),
      .com_i          (com_o),
      .mode_i         (mode_i),
      .disp_o         (disp_o)
   );

endmodule

`default_nettype wire

/* hdl/centroid_accum.sv */
`default_nettype none

module centroid_accum #(
   parameter int FRAME_W = video_pkg::FRAME_W_DEFAULT,
   parameter int FRAME_H = video_pkg::FRAME_H_DEFAULT
) (
   input  wire                   clk_camera,
   input  wire                   sys_rst_camera,
   input  wire                   mask_valid_i,
   input  wire                   mask_i,
   input  wire track_pkg::com_t  mask_pos_i,
   output track_pkg::com_t       com_o,
   output logic                  com_valid_o
);

   import video_pkg::*;
   import track_pkg::*;

   accum_state_e       state;
   logic [X_SUM_W-1:0] x_sum;
   logic [X_SUM_W-1:0] x_sum_next;
   logic [Y_SUM_W-1:0] y_sum;
   logic [Y_SUM_W-1:0] y_sum_next;
   logic [COUNT_W-1:0] count;
   logic [COUNT_W-1:0] count_next;
   logic               take_pixel;
   logic               last_pixel;
   logic               div_start;
   logic               x_done;
   logic               y_done;
   // dividers may finish on different cycles
   logic               x_done_seen;
   logic               y_done_seen;
   logic [X_SUM_W-1:0] x_quot;
   logic [Y_SUM_W-1:0] y_quot;

   always_comb begin
      take_pixel = mask_valid_i && mask_i;
      last_pixel = mask_valid_i
                && (mask_pos_i.x == hcount_t'(FRAME_W - 1))
                && (mask_pos_i.y == vcount_t'(FRAME_H - 1));
      x_sum_next = x_sum + (take_pixel ? X_SUM_W'(mask_pos_i.x) : '0);
      y_sum_next = y_sum + (take_pixel ? Y_SUM_W'(mask_pos_i.y) : '0);
      count_next = count + COUNT_W'(take_pixel);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state       <= ACC_COLLECT;
         x_sum       <= '0;
         y_sum       <= '0;
         count       <= '0;
         div_start   <= 1'b0;
         x_done_seen <= 1'b0;
         y_done_seen <= 1'b0;
         com_o       <= '0;
         com_valid_o <= 1'b0;
      end else begin
         div_start   <= 1'b0;
         com_valid_o <= 1'b0;
         case (state)
            ACC_COLLECT: begin
               x_sum <= x_sum_next;
               y_sum <= y_sum_next;
               count <= count_next;
               // empty frame stays here, sums are still zero
               if (last_pixel && (count_next != '0)) begin
                  state     <= ACC_DIVIDE;
                  div_start <= 1'b1;
               end
            end
            ACC_DIVIDE: begin
               x_done_seen <= x_done_seen | x_done;
               y_done_seen <= y_done_seen | y_done;
               if ((x_done_seen | x_done) && (y_done_seen | y_done)) begin
                  state <= ACC_HOLD;
               end
            end
            ACC_HOLD: begin
               // quotients are below the frame size, upper bits are zero
               com_o       <= '{x: hcount_t'(x_quot), y: vcount_t'(y_quot)};
               com_valid_o <= 1'b1;
               x_sum       <= '0;
               y_sum       <= '0;
               count       <= '0;
               x_done_seen <= 1'b0;
               y_done_seen <= 1'b0;
               state       <= ACC_COLLECT;
            end
            default: state <= ACC_COLLECT;
         endcase
      end
   end

   // divisor is the masked count, never zero at start
   serial_divider #(
      .DIV_W(X_SUM_W)
   ) x_div_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (x_sum),
      .divisor_i      (X_SUM_W'(count)),
      .quotient_o     (x_quot),
      .done_o         (x_done)
   );

   serial_divider #(
      .DIV_W(Y_SUM_W)
   ) y_div_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (y_sum),
      .divisor_i      (Y_SUM_W'(count)),
      .quotient_o     (y_quot),
      .done_o         (y_done)
   );

endmodule

`default_nettype wire

/* hdl/chroma_mask.sv */
`default_nettype none

module chroma_mask #(
   parameter track_pkg::chroma_t CR_LOW  = track_pkg::CR_LOW_DEFAULT,
   parameter track_pkg::chroma_t CR_HIGH = track_pkg::CR_HIGH_DEFAULT
) (
   input  wire                    clk_camera,
   input  wire                    sys_rst_camera,
   input  wire video_pkg::pixel_t pixel_i,
   output logic                   mask_valid_o,
   output logic                   mask_o,
   output track_pkg::com_t        mask_pos_o
);

   import track_pkg::*;

   // stage 1 holds the 8-bit channels
   logic               valid_s1;
   logic [7:0]         r8;
   logic [7:0]         g8;
   logic [7:0]         b8;
   com_t               pos_s1;
   // stage 2 holds cr
   logic               valid_s2;
   chroma_t            cr_s2;
   com_t               pos_s2;
   // cr before scaling, always positive for 8-bit inputs
   logic signed [16:0] cr_sum;

   always_comb begin
      cr_sum = 17'sd32768
             + 17'sd112 * $signed({9'd0, r8})
             - 17'sd94 * $signed({9'd0, g8})
             - 17'sd18 * $signed({9'd0, b8});
   end

   // valid strobes through the three stages
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         valid_s1     <= 1'b0;
         valid_s2     <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         valid_s1     <= pixel_i.valid;
         valid_s2     <= valid_s1;
         mask_valid_o <= valid_s2;
      end
   end

   always_ff @(posedge clk_camera) begin
      // stage 1: zero-pad r5 g6 b5 to 8 bits
      r8     <= {pixel_i.rgb[15:11], 3'b000};
      g8     <= {pixel_i.rgb[10:5], 2'b00};
      b8     <= {pixel_i.rgb[4:0], 3'b000};
      pos_s1 <= '{x: pixel_i.hcount, y: pixel_i.vcount};
      // stage 2: divide by 256, keep the low byte
      cr_s2  <= cr_sum[15:8];
      pos_s2 <= pos_s1;
      // stage 3: inclusive band test
      mask_o     <= (cr_s2 >= CR_LOW) && (cr_s2 <= CR_HIGH);
      mask_pos_o <= pos_s2;
   end

endmodule

`default_nettype wire

/* hdl/crosshair_overlay.sv */
`default_nettype none

module crosshair_overlay (
   input  wire                        clk_camera,
   input  wire                        sys_rst_camera,
   input  wire video_pkg::pixel_t     pixel_i,
   input  wire                        mask_valid_i,
   input  wire                        mask_i,
   input  wire track_pkg::com_t       com_i,
   input  wire video_pkg::disp_mode_e mode_i,
   output video_pkg::pixel_t          disp_o
);

   import video_pkg::*;

   // 3 stages to match the chroma pipeline
   pixel_t  pix_d [3];
   logic    on_cross;
   rgb565_t disp_rgb;

   always_comb begin
      // white lines through the last centre of mass
      on_cross = (pix_d[2].hcount == com_i.x) || (pix_d[2].vcount == com_i.y);
      if (on_cross) begin
         disp_rgb = 16'hFFFF;
      end else if (mode_i == DISP_MASK) begin
         disp_rgb = mask_i ? 16'hFFFF : 16'h0000;
      end else begin
         disp_rgb = pix_d[2].rgb;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pix_d[0] <= '0;
         pix_d[1] <= '0;
         pix_d[2] <= '0;
         disp_o   <= '0;
      end else begin
         pix_d[0] <= pixel_i;
         pix_d[1] <= pix_d[0];
         pix_d[2] <= pix_d[1];
         // mask_valid_i lands on the same cycle as the delayed pixel
         disp_o.valid  <= pix_d[2].valid & mask_valid_i;
         disp_o.hcount <= pix_d[2].hcount;
         disp_o.vcount <= pix_d[2].vcount;
         disp_o.rgb    <= disp_rgb;
      end
   end

endmodule

`default_nettype wire

/* hdl/pixel_capture.sv */
`default_nettype none

module pixel_capture #(
   parameter int FRAME_W = video_pkg::FRAME_W_DEFAULT,
   parameter int FRAME_H = video_pkg::FRAME_H_DEFAULT
) (
   input  wire                      clk_camera,
   input  wire                      sys_rst_camera,
   input  wire video_pkg::cam_bus_t bus_i,
   output video_pkg::pixel_t        pixel_o
);

   import video_pkg::*;

   // two-flop synchroniser on all camera pins
   cam_bus_t   bus_s1;
   cam_bus_t   bus_s2;
   // previous pin levels for edge detection
   logic       pclk_d;
   logic       hsync_d;
   logic       pclk_rise;
   logic       hsync_fall;
   // byte pairing
   logic       second_byte;
   logic [7:0] hi_byte;
   // position of the pixel being assembled
   hcount_t    hcount;
   vcount_t    vcount;

   always_ff @(posedge clk_camera) begin
      bus_s1 <= bus_i;
      bus_s2 <= bus_s1;
   end

   assign pclk_rise  = bus_s2.pclk & ~pclk_d;
   assign hsync_fall = ~bus_s2.hsync & hsync_d;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_d      <= 1'b0;
         hsync_d     <= 1'b0;
         second_byte <= 1'b0;
         hcount      <= '0;
         vcount      <= '0;
         pixel_o     <= '0;
      end else begin
         pclk_d        <= bus_s2.pclk;
         hsync_d       <= bus_s2.hsync;
         pixel_o.valid <= 1'b0;
         if (bus_s2.vsync) begin
            // frame blanking, restart at the top left
            hcount      <= '0;
            vcount      <= '0;
            second_byte <= 1'b0;
         end else if (hsync_fall) begin
            // end of line, rows saturate on an oversized frame
            hcount      <= '0;
            second_byte <= 1'b0;
            if (vcount != vcount_t'(FRAME_H - 1)) begin
               vcount <= vcount + 1'b1;
            end
         end else if (pclk_rise && bus_s2.hsync) begin
            second_byte <= ~second_byte;
            if (!second_byte) begin
               // high byte first: r5 and upper g3
               hi_byte <= bus_s2.data;
            end else begin
               pixel_o.valid  <= 1'b1;
               pixel_o.hcount <= hcount;
               pixel_o.vcount <= vcount;
               pixel_o.rgb    <= {hi_byte, bus_s2.data};
               // columns saturate too
               if (hcount != hcount_t'(FRAME_W - 1)) begin
                  hcount <= hcount + 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/serial_divider.sv */
`default_nettype none

module serial_divider #(
   parameter int DIV_W = 24
) (
   input  wire               clk_camera,
   input  wire               sys_rst_camera,
   input  wire               start_i,
   input  wire  [DIV_W-1:0]  dividend_i,
   input  wire  [DIV_W-1:0]  divisor_i,
   output logic [DIV_W-1:0]  quotient_o,
   output logic              done_o
);

   localparam int CNT_W = $clog2(DIV_W + 1);

   logic             busy;
   logic [CNT_W-1:0] bit_cnt;
   // partial remainder, dividend shifting out msb first
   logic [DIV_W-1:0] rem_q;
   logic [DIV_W-1:0] quo_q;
   logic [DIV_W-1:0] div_q;
   logic [DIV_W-1:0] rem_shift;
   // top bit set means the trial subtraction went negative
   logic [DIV_W:0]   trial;

   assign trial      = {rem_q, quo_q[DIV_W-1]} - {1'b0, div_q};
   assign rem_shift  = {rem_q[DIV_W-2:0], quo_q[DIV_W-1]};
   assign quotient_o = quo_q;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy    <= 1'b0;
         bit_cnt <= '0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (!busy) begin
            // start while busy is ignored
            if (start_i) begin
               busy    <= 1'b1;
               bit_cnt <= CNT_W'(DIV_W);
            end
         end else begin
            bit_cnt <= bit_cnt - CNT_W'(1);
            if (bit_cnt == CNT_W'(1)) begin
               busy   <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (!busy && start_i) begin
         rem_q <= '0;
         quo_q <= dividend_i;
         div_q <= divisor_i;
      end else if (busy) begin
         // restore on a negative trial, quotient bits enter at the lsb
         rem_q <= trial[DIV_W] ? rem_shift : trial[DIV_W-1:0];
         quo_q <= {quo_q[DIV_W-2:0], ~trial[DIV_W]};
      end
   end

endmodule

`default_nettype wire

/* hdl/track_pkg.sv */
`default_nettype none

package track_pkg;

   import video_pkg::*;

   // cr chroma value
   typedef logic [7:0] chroma_t;

   // inclusive cr band for the pink marker
   localparam chroma_t CR_LOW_DEFAULT  = 8'hA0;
   localparam chroma_t CR_HIGH_DEFAULT = 8'hF0;

   // per-frame coordinate sums
   // 320 x 180 frame fully masked still fits in 24 bits
   localparam int X_SUM_W = 24;
   localparam int Y_SUM_W = 24;

   // masked-pixel count, up to 57600 per frame
   localparam int COUNT_W = 17;

   // a position in the image, also used for the centre of mass
   typedef struct packed {
      hcount_t x;
      vcount_t y;
   } com_t;

   // centroid FSM
   typedef enum logic [1:0] {
      ACC_COLLECT = 2'd0,
      ACC_DIVIDE  = 2'd1,
      ACC_HOLD    = 2'd2
   } accum_state_e;

endpackage

`default_nettype wire

/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

   // default sensor window, the testbench shrinks it through the top level
   localparam int FRAME_W_DEFAULT = 320;
   localparam int FRAME_H_DEFAULT = 180;

   // column and row counts of the camera image
   typedef logic [8:0] hcount_t;
   typedef logic [7:0] vcount_t;

   // one camera pixel, r5 g6 b5
   typedef logic [15:0] rgb565_t;

   // pixel stream word
   // valid is a one-cycle strobe, the stream never stalls
   typedef struct packed {
      logic    valid;
      hcount_t hcount;
      vcount_t vcount;
      rgb565_t rgb;
   } pixel_t;

   // raw parallel camera pins, not yet in the clk_camera domain
   typedef struct packed {
      logic       pclk;
      logic       hsync;
      logic       vsync;
      logic [7:0] data;
   } cam_bus_t;

   // what the display stream shows under the crosshair
   typedef enum logic {
      DISP_CAMERA = 1'b0,
      DISP_MASK   = 1'b1
   } disp_mode_e;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f blob_tracker_top.f \
   --top-module tb_blob_tracker_top -o tb_blob_tracker_top
./obj_dir/tb_blob_tracker_top | tee sim.log
# a missing pass line fails the script
grep -q "TEST OK" sim.log
echo "simulation passed"

/* tests/frame_trace.txt */
// per frame a header of expected com x, com y and masked pixel count
// then four rows of eight rgb565 pixels, top row first
0005 0001 0004
0000 001F 07E0 8410 4000 FFFF 0000 001F
8410 0000 001F 07E0 4000 F800 F800 0000
0000 07E0 8410 001F 0000 F800 8000 4000
FFFF 0000 0000 8410 07E0 001F 0000 0000
0002 0002 0005
0000 0000 4800 8410 001F 07E0 0000 FFFF
07E0 4800 0000 0000 8410 0000 001F 0000
0000 0000 F800 5000 0000 4800 0000 8410
001F 6000 F800 F800 0000 0000 07E0 0000
0002 0002 0000
8410 0000 07E0 001F 4800 0000 FFFF 0000
0000 4000 0000 8410 0000 07E0 0000 001F
FFFF 0000 4800 0000 001F 0000 8410 0000
0000 07E0 0000 4000 0000 FFFF 0000 4800

/* tests/tb_blob_tracker_top.sv */
`default_nettype none

module tb_blob_tracker_top;

   import video_pkg::*;
   import track_pkg::*;

   localparam int          FRAME_W      = 8;
   localparam int          FRAME_H      = 4;
   localparam chroma_t     CR_LOW       = 8'hA0;
   localparam chroma_t     CR_HIGH      = 8'hF0;
   localparam int          N_FRAMES     = 3;
   // three header words, then one word per pixel
   localparam int          FRAME_WORDS  = 3 + FRAME_W * FRAME_H;
   localparam int          RESET_CYCLES = 8;
   // vsync blanking in pclk periods of 4 clk_camera cycles
   localparam int          VS_GAP       = 16;
   localparam int unsigned RAND_SEED    = 32'h9e5b_fc7d;
   // pixels at 8 cycles, longest line gaps, blanking and reset, plus half again
   localparam int TIMEOUT_CYCLES = (N_FRAMES * FRAME_W * FRAME_H * 8
                                  + N_FRAMES * FRAME_H * 12 * 4
                                  + (N_FRAMES + 1) * VS_GAP * 4
                                  + RESET_CYCLES) * 3 / 2;

   logic        clk_camera = 1'b0;
   logic        sys_rst_camera;
   cam_bus_t    cam_bus;
   disp_mode_e  disp_mode;
   pixel_t      disp;
   com_t        com;
   logic        com_valid;

   logic [15:0] trace_mem [0:N_FRAMES*FRAME_WORDS-1];
   // display pixels still to come in order
   pixel_t      exp_q [$];
   int          error_count = 0;
   int          check_count = 0;
   int          com_pulses  = 0;
   int          cycle_count = 0;

   blob_tracker_top #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H),
      .CR_LOW (CR_LOW),
      .CR_HIGH(CR_HIGH)
   ) dut_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_bus_i      (cam_bus),
      .mode_i         (disp_mode),
      .disp_o         (disp),
      .com_o          (com),
      .com_valid_o    (com_valid)
   );

   always #20 clk_camera = ~clk_camera;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
      end
   endtask

   // one pclk period with 2 cycles low and 2 cycles high
   task automatic bus_cycle(input logic [7:0] data, input logic hsync, input logic vsync);
      @(posedge clk_camera);
      cam_bus.pclk  <= 1'b0;
      cam_bus.hsync <= hsync;
      cam_bus.vsync <= vsync;
      cam_bus.data  <= data;
      repeat (2) @(posedge clk_camera);
      cam_bus.pclk <= 1'b1;
      @(posedge clk_camera);
   endtask

   // pads the channels with zeros and tests Cr scaled by 256 against the inclusive band
   function automatic logic cr_in_band(input logic [15:0] rgb);
      int      r8;
      int      g8;
      int      b8;
      int      sum;
      chroma_t cr;
      r8  = int'({rgb[15:11], 3'b000});
      g8  = int'({rgb[10:5], 2'b00});
      b8  = int'({rgb[4:0], 3'b000});
      sum = 32768 + 112 * r8 - 94 * g8 - 18 * b8;
      cr  = chroma_t'((sum >> 8) & 255);
      return (cr >= CR_LOW) && (cr <= CR_HIGH);
   endfunction

   // run limit
   always @(posedge clk_camera) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // outputs settle after the rising edge so they are sampled on the falling one
   always @(negedge clk_camera) begin : watch_outputs
      pixel_t exp_pix;
      if (disp.valid) begin
         if (exp_q.size() == 0) begin
            error_count++;
            $display("display pixel at column %0d row %0d came when none was expected",
                     disp.hcount, disp.vcount);
         end else begin
            exp_pix = exp_q.pop_front();
            check_value("disp_o.hcount", 32'(disp.hcount), 32'(exp_pix.hcount));
            check_value("disp_o.vcount", 32'(disp.vcount), 32'(exp_pix.vcount));
            check_value("disp_o.rgb", 32'(disp.rgb), 32'(exp_pix.rgb));
         end
      end
      if (com_valid) begin
         com_pulses++;
      end
   end

   initial begin : run_frames
      int          base;
      int          gap;
      int          n_mask;
      int          sum_x;
      int          sum_y;
      int          exp_pulses;
      logic [15:0] word;
      logic        masked;
      logic        show_mask;
      com_t        cur_com;
      pixel_t      exp_pix;

      void'($urandom(RAND_SEED));
      $readmemh("tests/frame_trace.txt", trace_mem);
      sys_rst_camera <= 1'b1;
      cam_bus        <= '0;
      disp_mode      <= DISP_CAMERA;
      cur_com        = '0;
      exp_pulses     = 0;

      // outputs stay quiet through reset and the cycle after it
      repeat (RESET_CYCLES - 1) begin
         @(negedge clk_camera);
         check_value("disp_o.valid in reset", 32'(disp.valid), 32'd0);
         check_value("com_valid_o in reset", 32'(com_valid), 32'd0);
      end
      @(posedge clk_camera);
      sys_rst_camera <= 1'b0;
      // the first edge with reset low shows at the second falling edge
      repeat (2) begin
         @(negedge clk_camera);
         check_value("disp_o.valid after reset", 32'(disp.valid), 32'd0);
         check_value("com_valid_o after reset", 32'(com_valid), 32'd0);
      end
      repeat (VS_GAP) bus_cycle(8'h00, 1'b0, 1'b1);

      for (int f = 0; f < N_FRAMES; f++) begin
         base      = f * FRAME_WORDS;
         n_mask    = 0;
         sum_x     = 0;
         sum_y     = 0;
         // even frames show the mask
         show_mask = (f % 2 == 0);
         @(posedge clk_camera);
         disp_mode <= show_mask ? DISP_MASK : DISP_CAMERA;
         for (int row = 0; row < FRAME_H; row++) begin
            for (int col = 0; col < FRAME_W; col++) begin
               word   = trace_mem[base + 3 + row * FRAME_W + col];
               masked = cr_in_band(word);
               if (masked) begin
                  n_mask++;
                  sum_x += col;
                  sum_y += row;
               end
               exp_pix.valid  = 1'b1;
               exp_pix.hcount = hcount_t'(col);
               exp_pix.vcount = vcount_t'(row);
               // crosshair from the previous frame wins in both modes
               if (exp_pix.hcount == cur_com.x || exp_pix.vcount == cur_com.y) begin
                  exp_pix.rgb = 16'hFFFF;
               end else if (show_mask) begin
                  exp_pix.rgb = masked ? 16'hFFFF : 16'h0000;
               end else begin
                  exp_pix.rgb = word;
               end
               exp_q.push_back(exp_pix);
               // high byte first
               bus_cycle(word[15:8], 1'b1, 1'b0);
               bus_cycle(word[7:0], 1'b1, 1'b0);
            end
            gap = 4 + int'($urandom % 32'd9);
            repeat (gap) bus_cycle(8'h00, 1'b0, 1'b0);
         end
         // trace header must match the masked pixels found here
         check_value("trace masked count", 32'(n_mask), 32'(trace_mem[base + 2]));
         if (n_mask > 0) begin
            check_value("trace com x", 32'(sum_x / n_mask), 32'(trace_mem[base]));
            check_value("trace com y", 32'(sum_y / n_mask), 32'(trace_mem[base + 1]));
         end
         // all pixels of the frame out before moving on
         while (exp_q.size() != 0) @(posedge clk_camera);
         if (trace_mem[base + 2] != 16'h0000) begin
            exp_pulses++;
            while (com_pulses != exp_pulses) @(posedge clk_camera);
            cur_com.x = hcount_t'(trace_mem[base]);
            cur_com.y = vcount_t'(trace_mem[base + 1]);
         end
         // empty frame keeps the old centre and sends no pulse
         repeat (VS_GAP) bus_cycle(8'h00, 1'b0, 1'b1);
         @(negedge clk_camera);
         check_value("com_valid_o pulses", com_pulses, exp_pulses);
         check_value("com_o.x", 32'(com.x), 32'(cur_com.x));
         check_value("com_o.y", 32'(com.y), 32'(cur_com.y));
      end

      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
